//--- Bender.yml
package:
  name: rv32i_multicycle

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/decoder.sv
      - rtl/control_unit.sv
      - rtl/register_file.sv
      - rtl/alu.sv
      - rtl/memory_unit.sv
      - rtl/cpu.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - bench/bus_memory.sv
      - bench/cpu_tb.sv

//--- bench/bus_memory.sv
`timescale 1ns/10ps

module bus_memory #(
  parameter int          WORDS = 256,
  parameter logic [15:0] SEED = 16'd33428
) (
  input  logic        clk,
  input  logic        instr_read,
  input  logic [31:0] instr_address,
  output logic        instr_waitrequest,
  output logic        instr_readdatavalid,
  output logic [31:0] instr_readdata,
  input  logic        data_read,
  input  logic        data_write,
  input  logic [31:0] data_address,
  input  logic [3:0]  data_byteenable,
  input  logic [31:0] data_writedata,
  output logic        data_waitrequest,
  output logic        data_readdatavalid,
  output logic [31:0] data_readdata
);

  logic [31:0] imem [WORDS];
  logic [7:0]  dmem [256];
  logic [15:0] lfsr = SEED;
  int          fetch_count = 0;
  int          store_count = 0;
  logic        instr_busy = 1'b0;
  logic        data_busy = 1'b0;
  int          instr_delay = 0;
  int          data_delay = 0;
  logic [31:0] instr_word;
  logic [31:0] data_word;

  // galois LFSR stepped once for every bit handed out.
  function logic [31:0] random_bits(input int n);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return value;
  endfunction

  initial begin
    instr_waitrequest = 1'b0;
    instr_readdatavalid = 1'b0;
    instr_readdata = '0;
    data_waitrequest = 1'b0;
    data_readdatavalid = 1'b0;
    data_readdata = '0;
  end

  // both ports live in one process so the random draws keep a fixed order.
  always @(posedge clk) begin : ports
    logic        instr_accept;
    logic        read_accept;
    logic        write_accept;
    logic [31:0] instr_addr;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    int          k;
    instr_accept = instr_read && !instr_waitrequest;
    read_accept = data_read && !data_waitrequest;
    write_accept = data_write && !data_waitrequest;
    instr_addr = instr_address;
    addr = data_address;
    be = data_byteenable;
    wdata = data_writedata;
    #5;
    instr_waitrequest = random_bits(2) == 0;
    data_waitrequest = random_bits(2) == 0;
    instr_readdatavalid = 1'b0;
    data_readdatavalid = 1'b0;
    if (instr_accept) begin
      fetch_count++;
      instr_busy = 1'b1;
      instr_delay = random_bits(2);
      instr_word = imem[instr_addr[$clog2(WORDS)+1:2]];
    end
    if (instr_busy) begin
      if (instr_delay == 0) begin
        instr_readdatavalid = 1'b1;
        instr_readdata = instr_word;
        instr_busy = 1'b0;
      end else begin
        instr_delay--;
      end
    end
    if (write_accept) begin
      for (k = 0; k < 4; k++) begin
        if (be[k]) begin
          dmem[{addr[7:2], 2'(k)}] = wdata[8*k +: 8];
        end
      end
      store_count++;
    end
    if (read_accept) begin
      data_busy = 1'b1;
      data_delay = random_bits(2);
      for (k = 0; k < 4; k++) begin
        data_word[8*k +: 8] = dmem[{addr[7:2], 2'(k)}]; // little endian lanes.
      end
    end
    if (data_busy) begin
      if (data_delay == 0) begin
        data_readdatavalid = 1'b1;
        data_readdata = data_word;
        data_busy = 1'b0;
      end else begin
        data_delay--;
      end
    end
  end

endmodule

//--- bench/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_tb;

  localparam int          PROG_WORDS = 256;
  localparam int          CLK_PERIOD = 100;
  localparam logic [31:0] END_PC = `CPU_RESET_PC + 4 * (PROG_WORDS - 1);

  logic        clk;
  logic        rst;
  logic        instr_read;
  logic [31:0] instr_address;
  logic        instr_waitrequest;
  logic        instr_readdatavalid;
  logic [31:0] instr_readdata;
  logic        data_read;
  logic        data_write;
  logic [31:0] data_address;
  logic [3:0]  data_byteenable;
  logic [31:0] data_writedata;
  logic        data_waitrequest;
  logic        data_readdatavalid;
  logic [31:0] data_readdata;
  logic [31:0] debug_current_pc;
  logic [31:0] debug_instruction;

  logic [31:0] prog [PROG_WORDS];
  logic [31:0] regs_m [32];
  logic [7:0]  dmem_m [256];
  logic [31:0] pc_m = `CPU_RESET_PC;
  logic [31:0] fetch_pc_m;
  logic [31:0] load_q [$];
  logic [67:0] store_q [$];
  int          errors = 0;
  int          model_steps = 0;
  int          model_stores = 0;
  logic        instr_held = 1'b0;
  logic        data_held = 1'b0;
  logic        check_ir = 1'b0;
  logic [31:0] held_instr_address;
  logic [69:0] held_data;

  cpu cpu_i (.*);

  bus_memory #(.WORDS(PROG_WORDS)) bus_memory_i (
    .clk, .instr_read, .instr_address, .instr_waitrequest, .instr_readdatavalid,
    .instr_readdata, .data_read, .data_write, .data_address, .data_byteenable,
    .data_writedata, .data_waitrequest, .data_readdatavalid, .data_readdata
  );

  function automatic logic [31:0] op_result(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return 32'($signed(a) < $signed(b));
      3'b011:  return 32'(a < b);
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // jumps only go forward so the random program always reaches its last word.
  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    logic        target [PROG_WORDS];
    int          i;
    int          t;
    int          kind;
    for (i = 0; i < PROG_WORDS; i++) begin
      target[i] = 1'b0;
    end
    i = 0;
    while (i < PROG_WORDS - 1) begin
      kind = bus_memory_i.random_bits(4);
      rd = 5'(1 + bus_memory_i.random_bits(3) % 7);
      ra = bus_memory_i.random_bits(3);
      rb = bus_memory_i.random_bits(3);
      f3 = bus_memory_i.random_bits(3);
      imm = bus_memory_i.random_bits(12);
      r = bus_memory_i.random_bits(20);
      t = i + 1 + bus_memory_i.random_bits(4);
      if (t > PROG_WORDS - 1) begin
        t = PROG_WORDS - 1;
      end
      if (kind == 15 && i + 3 <= PROG_WORDS - 1 && !target[i+1] && !target[i+2]) begin
        t = (t + 2 > PROG_WORDS - 1) ? PROG_WORDS - 1 : t + 2;
        prog[i] = {20'h00000, rd, 7'h37};
        prog[i+1] = {12'(4 * t), rd, 3'b000, rd, 7'h13};
        prog[i+2] = {12'h000, rd, 3'b000, 5'(1 + ra % 7), 7'h67};
        target[t] = 1'b1;
        i += 3;
      end else begin
        case (kind)
          0: prog[i] = {r[19:0], rd, 7'h37};
          1: prog[i] = {r[19:0], rd, 7'h17};
          2: begin
            joff = 21'(4 * (t - i));
            prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
            target[t] = 1'b1;
          end
          3, 4: begin
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            boff = 13'(4 * (t - i));
            prog[i] = {boff[12], boff[10:5], rb, ra, f3, boff[4:1], boff[11], 7'h63};
            target[t] = 1'b1;
          end
          5, 6: begin
            if (f3[1:0] == 2'b11) f3[1:0] = 2'b10;
            if (f3 == 3'b110) f3 = 3'b010;
            imm[11:8] = 4'h0;
            if (f3[1:0] == 2'b01) imm[0] = 1'b0;
            if (f3[1:0] == 2'b10) imm[1:0] = 2'b00;
            prog[i] = {imm, 5'd0, f3, rd, 7'h03};
          end
          7, 8: begin
            f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
            imm[11:8] = 4'h0;
            if (f3[1:0] == 2'b01) imm[0] = 1'b0;
            if (f3[1:0] == 2'b10) imm[1:0] = 2'b00;
            prog[i] = {imm[11:5], rb, 5'd0, f3, imm[4:0], 7'h23};
          end
          12, 13, 14: begin
            prog[i] = {(f3 == 3'b000 || f3 == 3'b101) ? {1'b0, imm[0], 5'b0} : 7'b0,
                       rb, ra, f3, rd, 7'h33};
          end
          default: begin
            if (f3 == 3'b001) imm[11:5] = 7'b0;
            if (f3 == 3'b101) imm[11:5] = {1'b0, imm[10], 5'b0}; // srli or srai.
            prog[i] = {imm, ra, f3, rd, 7'h13};
          end
        endcase
        i++;
      end
    end
    prog[PROG_WORDS-1] = 32'h0000006f; // jal x0, 0 parks the core.
  endtask

  task automatic step_model(input logic [31:0] w);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic [3:0]  be;
    logic        wr;
    logic        take;
    int          k;
    f3 = w[14:12];
    rd = w[11:7];
    a = regs_m[w[19:15]];
    b = regs_m[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    next_pc = pc_m + 4;
    res = pc_m + 4;
    wr = 1'b1;
    case (w[6:0])
      7'h37: res = {w[31:12], 12'h000};
      7'h17: res = pc_m + {w[31:12], 12'h000};
      7'h6f: next_pc = pc_m + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      7'h67: next_pc = (a + imm_i) & ~32'd1;
      7'h63: begin
        wr = 1'b0;
        case (f3)
          3'b000:  take = a == b;
          3'b001:  take = a != b;
          3'b100:  take = $signed(a) < $signed(b);
          3'b101:  take = $signed(a) >= $signed(b);
          3'b110:  take = a < b;
          default: take = a >= b;
        endcase
        if (take) next_pc = pc_m + imm_b;
      end
      7'h03: begin
        addr = a + imm_i;
        load_q.push_back({addr[31:2], 2'b00});
        for (k = 0; k < 4; k++) begin
          word[8*k +: 8] = dmem_m[8'(addr + k)];
        end
        case (f3)
          3'b000:  res = {{24{word[7]}}, word[7:0]};
          3'b001:  res = {{16{word[15]}}, word[15:0]};
          3'b100:  res = {24'h0, word[7:0]};
          3'b101:  res = {16'h0, word[15:0]};
          default: res = word;
        endcase
      end
      7'h23: begin
        wr = 1'b0;
        addr = a + imm_s;
        case (f3[1:0])
          2'b00:   be = 4'b0001 << addr[1:0];
          2'b01:   be = 4'b0011 << addr[1:0];
          default: be = 4'b1111;
        endcase
        word = (f3[1:0] == 2'b00) ? {4{b[7:0]}} : (f3[1:0] == 2'b01) ? {2{b[15:0]}} : b;
        for (k = 0; k < 4; k++) begin
          if (be[k]) dmem_m[{addr[7:2], 2'(k)}] = word[8*k +: 8];
        end
        store_q.push_back({addr[31:2], 2'b00, be, word});
        model_stores++;
      end
      7'h13: res = op_result(f3, w[30] && f3 == 3'b101, a, imm_i);
      7'h33: res = op_result(f3, w[30], a, b);
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) regs_m[rd] = res;
    pc_m = next_pc;
    model_steps++;
  endtask

  task automatic finish_run();
    $display("fetches %0d, stores %0d, errors %0d",
             model_steps, model_stores, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b0;
    build_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      bus_memory_i.imem[i] = prog[i];
    end
    for (int i = 0; i < 256; i++) begin
      dmem_m[i] = 8'(i * 37) ^ 8'h5a;
      bus_memory_i.dmem[i] = dmem_m[i];
    end
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (10) @(posedge clk);
    #5 rst = 1'b1;
  end

  initial begin
    #(PROG_WORDS * 20 * CLK_PERIOD);
    errors++;
    $display("timeout: the program never reached its final jump");
    finish_run();
  end

  always @(posedge clk) begin : monitor
    logic [67:0] exp_store;
    logic [31:0] exp_load;
    if (!rst) begin
      if (instr_read || data_read || data_write) begin
        errors++;
        $display("a bus request was raised during reset");
      end
    end else begin
      if (instr_held && (!instr_read || instr_address !== held_instr_address)) begin
        errors++;
        $display("instruction request changed while waitrequest was high");
      end
      if (data_held && {data_read, data_write, data_address, data_byteenable,
                        data_writedata} !== held_data) begin
        errors++;
        $display("data request changed while waitrequest was high");
      end
      if (check_ir) begin
        if (debug_current_pc !== fetch_pc_m) begin
          errors++;
          $display("[ERROR] debug_current_pc: got %h, expected %h",
                   debug_current_pc, fetch_pc_m);
        end
        if (debug_instruction !== prog[fetch_pc_m[9:2]]) begin
          errors++;
          $display("[ERROR] debug_instruction: got %h, expected %h",
                   debug_instruction, prog[fetch_pc_m[9:2]]);
        end
      end
      if (data_write && !data_waitrequest) begin
        if (store_q.size() == 0) begin
          errors++;
          $display("a store was issued that the program does not make");
        end else begin
          exp_store = store_q.pop_front();
          if (data_address !== exp_store[67:36]) begin
            errors++;
            $display("[ERROR] data_address: got %h, expected %h",
                     data_address, exp_store[67:36]);
          end
          if (data_byteenable !== exp_store[35:32]) begin
            errors++;
            $display("[ERROR] data_byteenable: got %h, expected %h",
                     data_byteenable, exp_store[35:32]);
          end
          if (data_writedata !== exp_store[31:0]) begin
            errors++;
            $display("[ERROR] data_writedata: got %h, expected %h",
                     data_writedata, exp_store[31:0]);
          end
        end
      end
      if (data_read && !data_waitrequest) begin
        if (load_q.size() == 0) begin
          errors++;
          $display("a load was issued that the program does not make");
        end else begin
          exp_load = load_q.pop_front();
          if (data_address !== exp_load) begin
            errors++;
            $display("[ERROR] data_address: got %h, expected %h", data_address, exp_load);
          end
        end
      end
    end
    instr_held = instr_read && instr_waitrequest;
    held_instr_address = instr_address;
    data_held = (data_read || data_write) && data_waitrequest;
    held_data = {data_read, data_write, data_address, data_byteenable, data_writedata};
    check_ir = rst && instr_readdatavalid; // the IR is loaded on this edge.
    if (rst && instr_read && !instr_waitrequest) begin
      fetch_pc_m = pc_m;
      if (instr_address !== pc_m) begin
        errors++;
        $display("[ERROR] instr_address: got %h, expected %h", instr_address, pc_m);
      end
      if (pc_m == END_PC) begin
        if (bus_memory_i.fetch_count != model_steps) begin
          errors++;
          $display("fetch count differs from the executed instruction count");
        end
        if (bus_memory_i.store_count != model_stores || store_q.size() != 0) begin
          errors++;
          $display("store count differs from the program's store count");
        end
        if (load_q.size() != 0) begin
          errors++;
          $display("some loads of the program never reached the bus");
        end
        finish_run();
      end else begin
        step_model(prog[pc_m[9:2]]);
      end
    end
  end

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu (
  input  cpu_pkg::alu_op_t     op,
  input  logic [`CPU_XLEN-1:0] a,
  input  logic [`CPU_XLEN-1:0] b,
  output logic [`CPU_XLEN-1:0] result
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {{(`CPU_XLEN-1){1'b0}}, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b; // LUI takes the upper immediate unchanged.
      default:    result = a + b;
    endcase
  end

endmodule

//--- rtl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::opcode_t  opcode,
  input  logic [2:0]        funct3,
  input  logic              funct7_5,
  input  logic              instr_read_done,
  input  logic              mem_done,
  output logic              instr_read,
  output logic              load_ir,
  output cpu_pkg::a_sel_t   a_sel,
  output cpu_pkg::b_sel_t   b_sel,
  output cpu_pkg::alu_op_t  alu_op,
  output cpu_pkg::wb_sel_t  wb_sel,
  output logic              reg_write,
  output logic              pc_load,
  output logic              pc_advance,
  output logic              branch,
  output logic              mem_start,
  output logic              mem_store
);
  import cpu_pkg::*;

  localparam logic [1:0] S_FETCH = 2'd0;
  localparam logic [1:0] S_EXECUTE = 2'd1;
  localparam logic [1:0] S_MEMORY = 2'd2;
  localparam logic [1:0] S_WRITEBACK = 2'd3;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       jump;
  logic       mem_access;

  function automatic alu_op_t funct_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  funct_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    a_sel = A_RS1;
    b_sel = B_IMM;
    alu_op = ALU_ADD;
    wb_sel = WB_NONE;
    jump = 1'b0;
    branch = 1'b0;
    mem_access = 1'b0;
    mem_store = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_op = ALU_PASS_B;
        wb_sel = WB_ALU;
      end
      OP_AUIPC: begin
        a_sel = A_PC;
        wb_sel = WB_ALU;
      end
      OP_JAL: begin
        a_sel = A_PC; // the ALU forms the target pc + imm.
        wb_sel = WB_PC4;
        jump = 1'b1;
      end
      OP_JALR: begin
        wb_sel = WB_PC4;
        jump = 1'b1;
      end
      OP_BRANCH: begin
        b_sel = B_RS2;
        branch = 1'b1;
        case (funct3[2:1])
          2'b10:   alu_op = ALU_SLT;
          2'b11:   alu_op = ALU_SLTU;
          default: alu_op = ALU_SUB; // equality looks at a zero difference.
        endcase
      end
      OP_LOAD: begin
        wb_sel = WB_LOAD;
        mem_access = 1'b1;
      end
      OP_STORE: begin
        mem_access = 1'b1;
        mem_store = 1'b1;
      end
      OP_IMM: begin
        alu_op = funct_op(funct3, funct7_5 && (funct3 == 3'b101)); // bit 30 is imm for ADDI.
        wb_sel = WB_ALU;
      end
      OP_OP: begin
        b_sel = B_RS2;
        alu_op = funct_op(funct3, funct7_5);
        wb_sel = WB_ALU;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (state)
      S_FETCH:   state_next = instr_read_done ? S_EXECUTE : S_FETCH;
      S_EXECUTE: state_next = mem_access ? S_MEMORY : S_WRITEBACK;
      S_MEMORY:  state_next = mem_done ? S_WRITEBACK : S_MEMORY;
      default:   state_next = S_FETCH;
    endcase
  end

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      state <= S_FETCH;
      instr_read <= 1'b0;
    end else begin
      state <= state_next;
      instr_read <= state_next == S_FETCH; // held for the whole fetch.
    end
  end

  assign load_ir = (state == S_FETCH) && instr_read_done;
  assign mem_start = (state == S_EXECUTE) && mem_access;
  assign reg_write = (state == S_WRITEBACK) && (wb_sel != WB_NONE);
  assign pc_advance = state == S_WRITEBACK;
  assign pc_load = (state == S_WRITEBACK) && (jump || branch);

  // the memory unit and the instruction port answer only the state that waits for them.
  assert property (@(posedge clk) disable iff (!rst) mem_done |-> state == S_MEMORY);
  assert property (@(posedge clk) disable iff (!rst) instr_read_done |-> state == S_FETCH);

endmodule

//--- rtl/cpu.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   instr_read,
  output logic [`CPU_XLEN-1:0]   instr_address,
  input  logic                   instr_waitrequest,
  input  logic                   instr_readdatavalid,
  input  logic [`CPU_XLEN-1:0]   instr_readdata,
  output logic                   data_read,
  output logic                   data_write,
  output logic [`CPU_XLEN-1:0]   data_address,
  output logic [`CPU_XLEN/8-1:0] data_byteenable,
  output logic [`CPU_XLEN-1:0]   data_writedata,
  input  logic                   data_waitrequest,
  input  logic                   data_readdatavalid,
  input  logic [`CPU_XLEN-1:0]   data_readdata,
  output logic [`CPU_XLEN-1:0]   debug_current_pc,
  output logic [`CPU_XLEN-1:0]   debug_instruction
);
  import cpu_pkg::*;

  instr_t               ir;
  opcode_t              opcode;
  a_sel_t               a_sel;
  b_sel_t               b_sel;
  alu_op_t              alu_op;
  wb_sel_t              wb_sel;
  logic [4:0]           rd;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [2:0]           funct3;
  logic                 funct7_5;
  logic [`CPU_XLEN-1:0] imm;
  logic [`CPU_XLEN-1:0] pc;
  logic [`CPU_XLEN-1:0] pc_plus4;
  logic [`CPU_XLEN-1:0] branch_target;
  logic [`CPU_XLEN-1:0] jump_target;
  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic [`CPU_XLEN-1:0] rd_data;
  logic [`CPU_XLEN-1:0] alu_a;
  logic [`CPU_XLEN-1:0] alu_b;
  logic [`CPU_XLEN-1:0] alu_result;
  logic [`CPU_XLEN-1:0] load_data;
  logic                 fetch_req;
  logic                 instr_pending;
  logic                 load_ir;
  logic                 reg_write;
  logic                 pc_load;
  logic                 pc_advance;
  logic                 branch;
  logic                 branch_taken;
  logic                 mem_start;
  logic                 mem_store;
  logic                 mem_done;

  decoder decoder_i (.ir, .opcode, .rd, .rs1, .rs2, .funct3, .funct7_5, .imm);

  control_unit control_unit_i (
    .clk, .rst, .opcode, .funct3, .funct7_5,
    .instr_read_done(instr_readdatavalid), .mem_done, .instr_read(fetch_req), .load_ir,
    .a_sel, .b_sel, .alu_op, .wb_sel, .reg_write, .pc_load, .pc_advance, .branch,
    .mem_start, .mem_store
  );

  register_file register_file_i (
    .clk, .rst, .rs1, .rs2, .rd, .rd_data, .write(reg_write), .rs1_data, .rs2_data
  );

  alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  memory_unit memory_unit_i (
    .clk, .rst, .start(mem_start), .store(mem_store), .funct3, .address(alu_result),
    .store_data(rs2_data), .data_waitrequest, .data_readdatavalid, .data_readdata,
    .data_read, .data_write, .data_address, .data_byteenable, .data_writedata,
    .load_data, .done(mem_done)
  );

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      instr_pending <= 1'b0;
      pc <= `CPU_RESET_PC;
    end else begin
      if (instr_read && !instr_waitrequest) begin
        instr_pending <= 1'b1; // accepted, now waiting for the word.
      end else if (instr_readdatavalid) begin
        instr_pending <= 1'b0;
      end
      if (pc_load && (!branch || branch_taken)) begin
        pc <= branch ? branch_target : jump_target;
      end else if (pc_advance) begin
        pc <= pc_plus4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_ir) begin
      ir <= instr_readdata;
    end
  end

  assign alu_a = (a_sel == A_PC) ? pc : rs1_data;
  assign alu_b = (b_sel == B_IMM) ? imm : rs2_data;

  always_comb begin
    case (wb_sel)
      WB_ALU:  rd_data = alu_result;
      WB_LOAD: rd_data = load_data;
      WB_PC4:  rd_data = pc_plus4;
      default: rd_data = '0;
    endcase
  end

  // the ALU compares, so a zero result means equal, or not less than.
  assign branch_taken = (alu_result == '0) ^ (funct3[2] ^ funct3[0]);
  assign pc_plus4 = pc + 32'd4;
  assign branch_target = pc + imm;
  assign jump_target = {alu_result[`CPU_XLEN-1:1], 1'b0};

  assign instr_read = fetch_req && !instr_pending;
  assign instr_address = pc;
  assign debug_current_pc = pc;
  assign debug_instruction = ir;

  assert property (@(posedge clk) disable iff (!rst)
    instr_read && instr_waitrequest |=> instr_read && $stable(instr_address));

endmodule

//--- rtl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// width of every data word, register and byte address in the core.
`define CPU_XLEN 32

// the first instruction is fetched from this address once reset is released.
`define CPU_RESET_PC 32'h0000_0000

// number of architectural registers, x0 included.
`define CPU_NREGS 32

`endif

//--- rtl/cpu_pkg.sv
package cpu_pkg;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic {
    A_RS1,
    A_PC
  } a_sel_t;

  typedef enum logic {
    B_RS2,
    B_IMM
  } b_sel_t;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_t;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

//--- rtl/decoder.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module decoder (
  input  cpu_pkg::instr_t      ir,
  output cpu_pkg::opcode_t     opcode,
  output logic [4:0]           rd,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic [2:0]           funct3,
  output logic                 funct7_5,
  output logic [`CPU_XLEN-1:0] imm
);
  import cpu_pkg::*;

  // register and funct fields sit at the same bits in every format.
  assign opcode   = opcode_t'(ir.r.opcode);
  assign rd       = ir.r.rd;
  assign rs1      = ir.r.rs1;
  assign rs2      = ir.r.rs2;
  assign funct3   = ir.r.funct3;
  assign funct7_5 = ir.r.funct7[5];

  always_comb begin
    case (opcode)
      OP_LOAD, OP_IMM, OP_JALR: begin
        imm = {{(`CPU_XLEN-12){ir.i.imm[11]}}, ir.i.imm};
      end
      OP_STORE: begin
        imm = {{(`CPU_XLEN-12){ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
      end
      OP_BRANCH: begin
        imm = {{(`CPU_XLEN-12){ir.b.imm_12}}, ir.b.imm_11, ir.b.imm_10_5,
               ir.b.imm_4_1, 1'b0}; // offsets are in half words.
      end
      OP_LUI, OP_AUIPC: begin
        imm = {ir.u.imm_31_12, 12'h000};
      end
      OP_JAL: begin
        imm = {{(`CPU_XLEN-20){ir.j.imm_20}}, ir.j.imm_19_12, ir.j.imm_11,
               ir.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- rtl/memory_unit.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module memory_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic                     store,
  input  logic [2:0]               funct3,
  input  logic [`CPU_XLEN-1:0]     address,
  input  logic [`CPU_XLEN-1:0]     store_data,
  input  logic                     data_waitrequest,
  input  logic                     data_readdatavalid,
  input  logic [`CPU_XLEN-1:0]     data_readdata,
  output logic                     data_read,
  output logic                     data_write,
  output logic [`CPU_XLEN-1:0]     data_address,
  output logic [`CPU_XLEN/8-1:0]   data_byteenable,
  output logic [`CPU_XLEN-1:0]     data_writedata,
  output logic [`CPU_XLEN-1:0]     load_data,
  output logic                     done
);

  logic                 waiting;
  logic [1:0]           offset;
  logic [2:0]           size;
  logic [`CPU_XLEN-1:0] read_word;
  logic [`CPU_XLEN-1:0] shifted;

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      data_read <= 1'b0;
      data_write <= 1'b0;
      waiting <= 1'b0;
    end else begin
      if (start) begin
        data_read <= !store;
        data_write <= store;
      end else if (!data_waitrequest) begin
        data_read <= 1'b0; // accepted, so the request drops.
        data_write <= 1'b0;
      end
      if (data_read && !data_waitrequest) begin
        waiting <= 1'b1;
      end else if (data_readdatavalid) begin
        waiting <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      data_address <= {address[`CPU_XLEN-1:2], 2'b00};
      offset <= address[1:0];
      size <= funct3;
      case (funct3[1:0])
        2'b00: begin
          data_byteenable <= 4'b0001 << address[1:0];
          data_writedata <= {4{store_data[7:0]}};
        end
        2'b01: begin
          data_byteenable <= 4'b0011 << {address[1], 1'b0};
          data_writedata <= {2{store_data[15:0]}};
        end
        default: begin
          data_byteenable <= 4'b1111;
          data_writedata <= store_data;
        end
      endcase
    end
    if (waiting && data_readdatavalid) begin
      read_word <= data_readdata;
    end
  end

  assign done = (data_write && !data_waitrequest) || (waiting && data_readdatavalid);
  assign shifted = read_word >> {offset, 3'b000}; // addressed byte moves to lane zero.

  always_comb begin
    case (size)
      3'b000:  load_data = {{(`CPU_XLEN-8){shifted[7]}}, shifted[7:0]};
      3'b001:  load_data = {{(`CPU_XLEN-16){shifted[15]}}, shifted[15:0]};
      3'b100:  load_data = {{(`CPU_XLEN-8){1'b0}}, shifted[7:0]};
      3'b101:  load_data = {{(`CPU_XLEN-16){1'b0}}, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

  // a new access starts only once the previous one has left the bus.
  assert property (@(posedge clk) disable iff (!rst)
    start |-> !data_read && !data_write && !waiting);

endmodule

//--- rtl/register_file.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module register_file (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(`CPU_NREGS)-1:0] rs1,
  input  logic [$clog2(`CPU_NREGS)-1:0] rs2,
  input  logic [$clog2(`CPU_NREGS)-1:0] rd,
  input  logic [`CPU_XLEN-1:0]          rd_data,
  input  logic                         write,
  output logic [`CPU_XLEN-1:0]          rs1_data,
  output logic [`CPU_XLEN-1:0]          rs2_data
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (rd != '0)) begin
      regs[rd] <= rd_data; // x0 is never written so it reads as zero.
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- verilog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/memory_unit.sv
rtl/cpu.sv
bench/bus_memory.sv
bench/cpu_tb.sv
